//--- pet_pkg.sv
`default_nettype none

package pet_pkg;

	// ====================
	// bus geometry
	// ====================

	// data bus is one 64-bit word, byte selects cover eight lanes
	localparam int PET_DATA_W = 64;
	// number of routed output lines
	localparam int PET_ROUTE_W = 56;
	// byte address, 8 KB window
	localparam int PET_ADR_W = 13;

	// core revision reported in capabilities
	localparam logic [7:0] PET_REV = 8'h01;

	// pulse outputs drop this many clocks after the hit
	localparam int PET_PULSE_LEN = 8;

	// ====================
	// register map
	// ====================

	// compare/control pairs fill 0x0000..0x0fff, 16 bytes per timer
	localparam logic [PET_ADR_W-1:0] PET_ADR_COUNTER = 13'h1000;
	localparam logic [PET_ADR_W-1:0] PET_ADR_MCTRL = 13'h1008;
	// first of four match status words, 64 timers each
	localparam logic [PET_ADR_W-1:0] PET_ADR_MSTAT0 = 13'h1010;
	localparam int PET_MSTAT_WORDS = 4;
	localparam logic [PET_ADR_W-1:0] PET_ADR_OSTAT = 13'h1030;
	localparam logic [PET_ADR_W-1:0] PET_ADR_CAPS = 13'h1038;

	// control word bit positions, route sits in 55:0
	localparam int PET_BIT_IE = 56;
	localparam int PET_BIT_PULSE = 57;
	localparam int PET_BIT_PERIODIC = 58;
	// comparator style, kept for software only
	localparam int PET_BIT_CST = 59;
	localparam int PET_BIT_CMPSEL = 60;
	// read-only output status of the timer
	localparam int PET_BIT_OSTAT = 63;

	// ====================
	// control types
	// ====================

	// per-timer control word as seen by the datapath
	typedef struct packed {
		// 0 = compare slot hits compare, 1 = addend (periodic only)
		logic cmp_sel;
		logic periodic;
		// 1 = pulse output, 0 = level
		logic pulse;
		logic ie;
		logic [PET_ROUTE_W-1:0] route;
	} pet_timer_cfg_t;

	// master control word
	typedef struct packed {
		logic irq_en;
		logic count_en;
	} pet_mctrl_t;

endpackage

`default_nettype wire

//--- pet_counter.sv
`default_nettype none
`timescale 1ns/1ps

module pet_counter #(
	parameter int BITS = 48
) (
	input wire clk_i,
	input wire rst_i,
	// count enable from master control
	input wire en_i,
	// software load, honored only while stopped
	input wire load_i,
	input wire [BITS-1:0] load_value_i,
	output logic [BITS-1:0] count_o
);

	// ====================
	// master count
	// ====================

	// free-running up counter
	// a load while running is dropped, software must stop the count first
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			count_o <= '0;
		end else if (en_i) begin
			count_o <= count_o + 1'b1;
		end else if (load_i) begin
			count_o <= load_value_i;
		end
	end

endmodule

`default_nettype wire

//--- pet_comparator.sv
`default_nettype none
`timescale 1ns/1ps

module pet_comparator #(
	parameter int BITS = 48
) (
	input wire clk_i,
	input wire rst_i,
	input wire [BITS-1:0] count_i,
	// reload compare by addend on each hit
	input wire periodic_i,
	// bus write strobes, one cycle each
	input wire cmp_wr_i,
	input wire add_wr_i,
	input wire [BITS-1:0] wr_data_i,
	// clear of the match status bit
	input wire ms_clr_i,
	output logic [BITS-1:0] compare_o,
	output logic ms_o,
	// unregistered, high in the cycle before ms sets
	output logic hit_o
);

	logic [BITS-1:0] compare_q;
	logic [BITS-1:0] addend_q;
	logic ms_q;

	// a timer fires once per status clear
	assign hit_o = (count_i == compare_q) && !ms_q;

	// ====================
	// compare and status
	// ====================

	// all ones keeps an idle timer far from a zero count
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			compare_q <= '1;
			ms_q <= 1'b0;
		end else begin
			// software write takes priority over the periodic step
			if (cmp_wr_i) begin
				compare_q <= wr_data_i;
			end else if (hit_o && periodic_i) begin
				compare_q <= compare_q + addend_q;
			end
			// hit wins over a clear in the same cycle
			if (hit_o) begin
				ms_q <= 1'b1;
			end else if (ms_clr_i) begin
				ms_q <= 1'b0;
			end
		end
	end

	// addend only matters once a periodic timer hits
	always_ff @(posedge clk_i) begin
		if (add_wr_i) begin
			addend_q <= wr_data_i;
		end
	end

	assign compare_o = compare_q;
	assign ms_o = ms_q;

	// status is sticky until software clears it
	a_ms_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
		ms_q && !ms_clr_i |=> ms_q);

endmodule

`default_nettype wire

//--- pet_output.sv
`default_nettype none
`timescale 1ns/1ps

module pet_output #(
	parameter int NTIMER = 8
) (
	input wire clk_i,
	input wire rst_i,
	input wire [NTIMER-1:0] hit_i,
	input wire pet_pkg::pet_timer_cfg_t [NTIMER-1:0] cfg_i,
	input wire pet_pkg::pet_mctrl_t mctrl_i,
	// software clear from the output status word
	input wire clr_i,
	input wire [pet_pkg::PET_ROUTE_W-1:0] clr_mask_i,
	output logic [pet_pkg::PET_ROUTE_W-1:0] out_o,
	output logic irq_o
);

	// hit that passes both interrupt enables
	logic [NTIMER-1:0] qhit;
	// pulse length reached this cycle
	logic [NTIMER-1:0] expire;
	// per-timer pulse counter, idles at PET_PULSE_LEN
	logic [NTIMER-1:0][3:0] pcnt_q;
	logic [pet_pkg::PET_ROUTE_W-1:0] out_d;

	always_comb begin
		for (int i = 0; i < NTIMER; i++) begin
			qhit[i] = hit_i[i] && cfg_i[i].ie && mctrl_i.irq_en;
			expire[i] = pcnt_q[i] == 4'(pet_pkg::PET_PULSE_LEN - 1);
		end
	end

	// ====================
	// output vector
	// ====================

	// clears first, then new hits, so a set in the same cycle survives
	always_comb begin
		out_d = out_o;
		for (int i = 0; i < NTIMER; i++) begin
			// level timers ignore their counter
			if (expire[i] && cfg_i[i].pulse) begin
				out_d = out_d & ~cfg_i[i].route;
			end
		end
		if (clr_i) begin
			out_d = out_d & ~clr_mask_i;
		end
		for (int i = 0; i < NTIMER; i++) begin
			if (qhit[i]) begin
				out_d = out_d | cfg_i[i].route;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			out_o <= '0;
			for (int i = 0; i < NTIMER; i++) begin
				pcnt_q[i] <= 4'(pet_pkg::PET_PULSE_LEN);
			end
		end else begin
			out_o <= out_d;
			for (int i = 0; i < NTIMER; i++) begin
				// restart on each qualified hit, then run up to idle
				if (qhit[i]) begin
					pcnt_q[i] <= '0;
				end else if (pcnt_q[i] != 4'(pet_pkg::PET_PULSE_LEN)) begin
					pcnt_q[i] <= pcnt_q[i] + 1'b1;
				end
			end
		end
	end

	// any active output raises the request
	assign irq_o = |out_o;

endmodule

`default_nettype wire

//--- pet_regs.sv
`default_nettype none
`timescale 1ns/1ps

module pet_regs #(
	parameter int NTIMER = 8,
	parameter int BITS = 48
) (
	input wire clk_i,
	input wire rst_i,
	// bus slave side
	input wire cs_i,
	input wire cyc_i,
	input wire stb_i,
	input wire we_i,
	input wire [pet_pkg::PET_DATA_W/8-1:0] sel_i,
	input wire [pet_pkg::PET_ADR_W-1:0] adr_i,
	input wire [pet_pkg::PET_DATA_W-1:0] dat_i,
	output logic ack_o,
	output logic [pet_pkg::PET_DATA_W-1:0] dat_o,
	// datapath status
	input wire [BITS-1:0] count_i,
	input wire [NTIMER-1:0][BITS-1:0] compare_i,
	input wire [NTIMER-1:0] ms_i,
	input wire [pet_pkg::PET_ROUTE_W-1:0] out_i,
	// counter load
	output logic cnt_load_o,
	output logic [BITS-1:0] cnt_value_o,
	// comparator strobes
	output logic [NTIMER-1:0] cmp_wr_o,
	output logic [NTIMER-1:0] add_wr_o,
	output logic [BITS-1:0] wr_data_o,
	output logic [NTIMER-1:0] ms_clr_o,
	// configuration
	output pet_pkg::pet_timer_cfg_t [NTIMER-1:0] cfg_o,
	output pet_pkg::pet_mctrl_t mctrl_o,
	output logic out_clr_o,
	output logic [pet_pkg::PET_ROUTE_W-1:0] out_clr_mask_o
);

	// word addresses of the upper registers
	localparam logic [9:0] W_COUNTER = 10'(pet_pkg::PET_ADR_COUNTER >> 3);
	localparam logic [9:0] W_MCTRL = 10'(pet_pkg::PET_ADR_MCTRL >> 3);
	localparam logic [9:0] W_MSTAT0 = 10'(pet_pkg::PET_ADR_MSTAT0 >> 3);
	localparam logic [9:0] W_OSTAT = 10'(pet_pkg::PET_ADR_OSTAT >> 3);
	localparam logic [9:0] W_CAPS = 10'(pet_pkg::PET_ADR_CAPS >> 3);
	// femtoseconds per tick, 20 MHz time base
	localparam logic [31:0] TIME_BASIS = 32'd50_000_000;
	// time basis, counter bytes - 1, vendor id 0, timers - 1, revision
	localparam logic [pet_pkg::PET_DATA_W-1:0] CAPS = {TIME_BASIS, 4'(BITS / 8 - 1),
		12'h000, 8'(NTIMER - 1), pet_pkg::PET_REV};

	logic cs_act;
	logic wr_act;
	logic rd_act;
	logic rd_ack;
	logic rdy_q;
	logic [9:0] wadr;
	logic [9:0] mword;
	logic is_mstat;
	logic [NTIMER-1:0] cmp_slot;
	logic [NTIMER-1:0] ctl_slot;
	pet_pkg::pet_timer_cfg_t [NTIMER-1:0] cfg_q;
	// comparator style bits, read back only
	logic [NTIMER-1:0] cst_q;
	pet_pkg::pet_mctrl_t mctrl_q;
	logic [pet_pkg::PET_DATA_W-1:0] rdata;

	// ====================
	// bus handshake
	// ====================

	assign cs_act = cs_i & cyc_i & stb_i;
	assign wr_act = cs_act & we_i;
	assign rd_act = cs_act & ~we_i;

	// reads take one wait state, rdy drops after each ack
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rdy_q <= 1'b0;
		end else begin
			rdy_q <= rd_act & ~rdy_q;
		end
	end

	assign rd_ack = rd_act & rdy_q;
	assign ack_o = wr_act | rd_ack;
	assign dat_o = rd_ack ? rdata : '0;

	// ====================
	// address decode
	// ====================

	assign wadr = adr_i[pet_pkg::PET_ADR_W-1:3];
	assign mword = wadr - W_MSTAT0;
	assign is_mstat = wadr >= W_MSTAT0 && wadr < W_MSTAT0 + 10'(pet_pkg::PET_MSTAT_WORDS);

	// timer index in 11:4, bit 3 picks control over compare
	always_comb begin
		for (int i = 0; i < NTIMER; i++) begin
			cmp_slot[i] = !adr_i[12] && adr_i[11:4] == 8'(i) && !adr_i[3];
			ctl_slot[i] = !adr_i[12] && adr_i[11:4] == 8'(i) && adr_i[3];
		end
	end

	// write strobes land at the edge that ends the write
	always_comb begin
		for (int i = 0; i < NTIMER; i++) begin
			add_wr_o[i] = wr_act && cmp_slot[i] && cfg_q[i].periodic && cfg_q[i].cmp_sel;
			cmp_wr_o[i] = wr_act && cmp_slot[i] && !(cfg_q[i].periodic && cfg_q[i].cmp_sel);
			// a one in the status word clears that timer
			ms_clr_o[i] = wr_act && is_mstat && mword == 10'(i / 64) && dat_i[i % 64];
		end
	end

	assign wr_data_o = dat_i[BITS-1:0];
	assign cnt_load_o = wr_act && wadr == W_COUNTER;
	assign cnt_value_o = dat_i[BITS-1:0];
	assign out_clr_o = wr_act && wadr == W_OSTAT;
	assign out_clr_mask_o = dat_i[pet_pkg::PET_ROUTE_W-1:0];

	// ====================
	// control registers
	// ====================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cfg_q <= '0;
			cst_q <= '0;
			mctrl_q <= '0;
		end else begin
			if (wr_act && wadr == W_MCTRL && sel_i[0]) begin
				mctrl_q.count_en <= dat_i[0];
				mctrl_q.irq_en <= dat_i[1];
			end
			for (int i = 0; i < NTIMER; i++) begin
				// next compare-slot write goes to the addend
				if (cmp_wr_o[i]) begin
					cfg_q[i].cmp_sel <= 1'b1;
				end
				if (wr_act && ctl_slot[i]) begin
					// route bytes under their lane selects
					for (int b = 0; b < pet_pkg::PET_ROUTE_W / 8; b++) begin
						if (sel_i[b]) begin
							cfg_q[i].route[b*8 +: 8] <= dat_i[b*8 +: 8];
						end
					end
					// top byte holds the mode bits
					if (sel_i[7]) begin
						cfg_q[i].ie <= dat_i[pet_pkg::PET_BIT_IE];
						cfg_q[i].pulse <= dat_i[pet_pkg::PET_BIT_PULSE];
						cfg_q[i].periodic <= dat_i[pet_pkg::PET_BIT_PERIODIC];
						cfg_q[i].cmp_sel <= dat_i[pet_pkg::PET_BIT_CMPSEL];
						cst_q[i] <= dat_i[pet_pkg::PET_BIT_CST];
					end
				end
			end
		end
	end

	assign cfg_o = cfg_q;
	assign mctrl_o = mctrl_q;

	// ====================
	// read data
	// ====================

	always_comb begin
		rdata = '0;
		for (int i = 0; i < NTIMER; i++) begin
			if (cmp_slot[i]) begin
				rdata[BITS-1:0] = compare_i[i];
			end
			if (ctl_slot[i]) begin
				rdata[pet_pkg::PET_ROUTE_W-1:0] = cfg_q[i].route;
				rdata[pet_pkg::PET_BIT_IE] = cfg_q[i].ie;
				rdata[pet_pkg::PET_BIT_PULSE] = cfg_q[i].pulse;
				rdata[pet_pkg::PET_BIT_PERIODIC] = cfg_q[i].periodic;
				rdata[pet_pkg::PET_BIT_CST] = cst_q[i];
				rdata[pet_pkg::PET_BIT_CMPSEL] = cfg_q[i].cmp_sel;
				// set while any of this timer's outputs is active
				rdata[pet_pkg::PET_BIT_OSTAT] = |(out_i & cfg_q[i].route);
			end
			if (is_mstat && mword == 10'(i / 64)) begin
				rdata[i % 64] = ms_i[i];
			end
		end
		case (wadr)
			W_COUNTER: rdata[BITS-1:0] = count_i;
			W_MCTRL: rdata[1:0] = {mctrl_q.irq_en, mctrl_q.count_en};
			W_OSTAT: rdata[pet_pkg::PET_ROUTE_W-1:0] = out_i;
			W_CAPS: rdata = CAPS;
			default: ;
		endcase
	end

	// a fresh read always waits one clock
	a_rd_wait: assert property (@(posedge clk_i) disable iff (rst_i)
		rd_act && !$past(rd_act) |-> !ack_o);

	// at most one compare or addend strobe across all timers per cycle
	a_wr_excl: assert property (@(posedge clk_i) disable iff (rst_i)
		$onehot0({cmp_wr_o, add_wr_o}));

endmodule

`default_nettype wire

//--- pet_top.sv
`default_nettype none
`timescale 1ns/1ps

module pet_top #(
	parameter int NTIMER = 8,
	parameter int BITS = 48
) (
	input wire clk_i,
	input wire rst_i,
	input wire cs_i,
	input wire cyc_i,
	input wire stb_i,
	input wire we_i,
	input wire [pet_pkg::PET_DATA_W/8-1:0] sel_i,
	input wire [pet_pkg::PET_ADR_W-1:0] adr_i,
	input wire [pet_pkg::PET_DATA_W-1:0] dat_i,
	output logic ack_o,
	output logic [pet_pkg::PET_DATA_W-1:0] dat_o,
	// routed timer outputs and their combined request
	output logic [pet_pkg::PET_ROUTE_W-1:0] out_o,
	output logic irq_o
);

	logic [BITS-1:0] count;
	logic cnt_load;
	logic [BITS-1:0] cnt_value;
	logic [NTIMER-1:0][BITS-1:0] compare;
	logic [NTIMER-1:0] ms;
	logic [NTIMER-1:0] hit;
	logic [NTIMER-1:0] cmp_wr;
	logic [NTIMER-1:0] add_wr;
	logic [NTIMER-1:0] ms_clr;
	logic [BITS-1:0] wr_data;
	pet_pkg::pet_timer_cfg_t [NTIMER-1:0] cfg;
	pet_pkg::pet_mctrl_t mctrl;
	logic out_clr;
	logic [pet_pkg::PET_ROUTE_W-1:0] out_clr_mask;

	// ====================
	// control
	// ====================

	pet_regs #(
		.NTIMER(NTIMER),
		.BITS(BITS)
	) u_regs (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.cs_i(cs_i),
		.cyc_i(cyc_i),
		.stb_i(stb_i),
		.we_i(we_i),
		.sel_i(sel_i),
		.adr_i(adr_i),
		.dat_i(dat_i),
		.ack_o(ack_o),
		.dat_o(dat_o),
		.count_i(count),
		.compare_i(compare),
		.ms_i(ms),
		.out_i(out_o),
		.cnt_load_o(cnt_load),
		.cnt_value_o(cnt_value),
		.cmp_wr_o(cmp_wr),
		.add_wr_o(add_wr),
		.wr_data_o(wr_data),
		.ms_clr_o(ms_clr),
		.cfg_o(cfg),
		.mctrl_o(mctrl),
		.out_clr_o(out_clr),
		.out_clr_mask_o(out_clr_mask)
	);

	// ====================
	// datapath
	// ====================

	pet_counter #(
		.BITS(BITS)
	) u_counter (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.en_i(mctrl.count_en),
		.load_i(cnt_load),
		.load_value_i(cnt_value),
		.count_o(count)
	);

	// one comparator per timer, all watching the same count
	for (genvar g = 0; g < NTIMER; g++) begin : g_cmp
		pet_comparator #(
			.BITS(BITS)
		) u_cmp (
			.clk_i(clk_i),
			.rst_i(rst_i),
			.count_i(count),
			.periodic_i(cfg[g].periodic),
			.cmp_wr_i(cmp_wr[g]),
			.add_wr_i(add_wr[g]),
			.wr_data_i(wr_data),
			.ms_clr_i(ms_clr[g]),
			.compare_o(compare[g]),
			.ms_o(ms[g]),
			.hit_o(hit[g])
		);
	end

	pet_output #(
		.NTIMER(NTIMER)
	) u_output (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.hit_i(hit),
		.cfg_i(cfg),
		.mctrl_i(mctrl),
		.clr_i(out_clr),
		.clr_mask_i(out_clr_mask),
		.out_o(out_o),
		.irq_o(irq_o)
	);

endmodule

`default_nettype wire

//--- tb_pet.sv
`default_nettype none
`timescale 1ns/1ps

module tb_pet;

	localparam int NTIMER = 8;
	localparam int BITS = 48;
	localparam int CLK_NS = 8;
	// bus cycles to wait for ack, counter reads to wait for a match
	localparam int ACK_LIMIT = 16;
	localparam int POLL_LIMIT = 100;
	// clock budget of each test, in run order
	localparam int TEST_CLOCKS = 60 + 60 + 200 + 200 + 250 + 250;
	localparam int WATCHDOG_NS = 2 * TEST_CLOCKS * CLK_NS;
	localparam logic [63:0] CMP_ONES = (64'd1 << BITS) - 1;

	logic clk_i;
	logic rst_i;
	logic cs_i;
	logic cyc_i;
	logic stb_i;
	logic we_i;
	logic [7:0] sel_i;
	logic [12:0] adr_i;
	logic [63:0] dat_i;
	logic ack_o;
	logic [63:0] dat_o;
	logic [55:0] out_o;
	logic irq_o;

	logic [15:0] lfsr_q;
	int errors;
	int tests_ok;
	int tests_bad;

	pet_top #(
		.NTIMER(NTIMER),
		.BITS(BITS)
	) dut_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.cs_i(cs_i),
		.cyc_i(cyc_i),
		.stb_i(stb_i),
		.we_i(we_i),
		.sel_i(sel_i),
		.adr_i(adr_i),
		.dat_i(dat_i),
		.ack_o(ack_o),
		.dat_o(dat_o),
		.out_o(out_o),
		.irq_o(irq_o)
	);

	always #(CLK_NS / 2) clk_i = ~clk_i;

	// ====================
	// helpers
	// ====================

	// 16-bit galois lfsr, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hb400;
		end
		return s >> 1;
	endfunction

	// one lfsr step per bit taken
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			r = {r[62:0], lfsr_q[0]};
		end
		return r;
	endfunction

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic bus_idle;
		cs_i = 1'b0;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i = 1'b0;
		sel_i = '0;
		adr_i = '0;
		dat_i = '0;
	endtask

	// drive on the falling edge, sample ack and data on a later falling edge
	task automatic bus_access(input logic we, input logic [12:0] adr, input logic [63:0] wdata,
		output logic [63:0] rdata);
		int n;
		@(negedge clk_i);
		cs_i = 1'b1;
		cyc_i = 1'b1;
		stb_i = 1'b1;
		we_i = we;
		sel_i = 8'hff;
		adr_i = adr;
		dat_i = wdata;
		n = 0;
		@(negedge clk_i);
		while (!ack_o && n < ACK_LIMIT) begin
			@(negedge clk_i);
			n++;
		end
		if (!ack_o) begin
			$display("error at %0t ns: no acknowledge for access to %h", $time, adr);
			errors++;
		end
		rdata = dat_o;
		bus_idle();
	endtask

	task automatic bus_write(input logic [12:0] adr, input logic [63:0] data);
		logic [63:0] unused;
		bus_access(1'b1, adr, data, unused);
	endtask

	task automatic bus_read(input logic [12:0] adr, output logic [63:0] data);
		bus_access(1'b0, adr, '0, data);
	endtask

	// control word of one timer, cst left at zero
	task automatic config_timer(input int t, input logic [63:0] route, input logic ie,
		input logic pulse, input logic periodic, input logic cmp_sel);
		logic [63:0] data;
		data = '0;
		data[55:0] = route[55:0];
		data[pet_pkg::PET_BIT_IE] = ie;
		data[pet_pkg::PET_BIT_PULSE] = pulse;
		data[pet_pkg::PET_BIT_PERIODIC] = periodic;
		data[pet_pkg::PET_BIT_CMPSEL] = cmp_sel;
		bus_write(13'(t * 16 + 8), data);
	endtask

	// poll the counter until it reads above limit
	task automatic wait_count_past(input logic [63:0] limit);
		logic [63:0] v;
		int n;
		v = '0;
		n = 0;
		while (v <= limit && n < POLL_LIMIT) begin
			bus_read(pet_pkg::PET_ADR_COUNTER, v);
			n++;
		end
		if (v <= limit) begin
			$display("error at %0t ns: counter never passed %h", $time, limit);
			errors++;
		end
	endtask

	// stopped counter loaded below c, compare at c, then run
	task automatic arm_timer(input int t, input logic ie, input logic pulse, input logic irq_en,
		output logic [63:0] route, output logic [63:0] c);
		logic [63:0] off;
		// disjoint windows per timer keep old compares out of reach
		c = 64'h10000 * (t + 1) + rand_bits(8);
		off = 8 + rand_bits(4);
		route = rand_bits(56) | 64'd1;
		bus_write(pet_pkg::PET_ADR_MCTRL, 64'd0);
		bus_write(pet_pkg::PET_ADR_COUNTER, c - off);
		config_timer(t, route, ie, pulse, 1'b0, 1'b0);
		bus_write(13'(t * 16), c);
		bus_write(pet_pkg::PET_ADR_MCTRL, {62'd0, irq_en, 1'b1});
	endtask

	task automatic finish_test(input string name, input int e0);
		if (errors == e0) begin
			tests_ok++;
			$display("test %s: ok", name);
		end else begin
			tests_bad++;
			$display("test %s: %0d errors", name, errors - e0);
		end
	endtask

	// ====================
	// tests
	// ====================

	task automatic reset_values;
		int e0;
		logic [63:0] v;
		e0 = errors;
		check("ack_o", ack_o, 0);
		check("out_o", out_o, 0);
		check("irq_o", irq_o, 0);
		bus_read(pet_pkg::PET_ADR_CAPS, v);
		check("caps revision", v[7:0], pet_pkg::PET_REV);
		check("caps timers", v[15:8], NTIMER - 1);
		bus_read(pet_pkg::PET_ADR_COUNTER, v);
		check("counter", v, 0);
		bus_read(pet_pkg::PET_ADR_MCTRL, v);
		check("mctrl", v, 0);
		bus_read(pet_pkg::PET_ADR_MSTAT0, v);
		check("mstat", v, 0);
		for (int t = 0; t < NTIMER; t++) begin
			bus_read(13'(t * 16), v);
			check("compare", v, CMP_ONES);
		end
		finish_test("reset values", e0);
	endtask

	task automatic counter_control;
		int e0;
		logic [63:0] v;
		logic [63:0] a;
		logic [63:0] b;
		e0 = errors;
		v = rand_bits(32);
		bus_write(pet_pkg::PET_ADR_COUNTER, v);
		bus_read(pet_pkg::PET_ADR_COUNTER, a);
		check("counter", a, v);
		bus_write(pet_pkg::PET_ADR_MCTRL, 64'd1);
		bus_read(pet_pkg::PET_ADR_COUNTER, a);
		bus_read(pet_pkg::PET_ADR_COUNTER, b);
		check("counter increasing", b > a, 1);
		// load while running must be dropped
		bus_write(pet_pkg::PET_ADR_COUNTER, 64'd0);
		bus_read(pet_pkg::PET_ADR_COUNTER, a);
		check("counter after running load", a > b, 1);
		bus_write(pet_pkg::PET_ADR_MCTRL, 64'd0);
		finish_test("counter control", e0);
	endtask

	task automatic level_match;
		int e0;
		logic [63:0] route;
		logic [63:0] c;
		logic [63:0] v;
		e0 = errors;
		arm_timer(1, 1'b1, 1'b0, 1'b1, route, c);
		wait_count_past(c);
		bus_read(pet_pkg::PET_ADR_MSTAT0, v);
		check("mstat bit", v[1], 1);
		check("out_o", out_o, route);
		check("irq_o", irq_o, 1);
		// level output holds well past where a pulse would drop
		repeat (pet_pkg::PET_PULSE_LEN + 2) begin
			@(negedge clk_i);
			check("irq_o", irq_o, 1);
		end
		bus_write(pet_pkg::PET_ADR_OSTAT, route);
		check("out_o", out_o, 0);
		check("irq_o", irq_o, 0);
		bus_write(pet_pkg::PET_ADR_MSTAT0, 64'd1 << 1);
		bus_read(pet_pkg::PET_ADR_MSTAT0, v);
		check("mstat bit", v[1], 0);
		bus_write(pet_pkg::PET_ADR_MCTRL, 64'd0);
		finish_test("level match", e0);
	endtask

	task automatic pulse_match;
		int e0;
		logic [63:0] route;
		logic [63:0] c;
		logic [63:0] v;
		e0 = errors;
		arm_timer(2, 1'b1, 1'b1, 1'b1, route, c);
		wait_count_past(c);
		// at most two clocks past the hit edge, so the pulse is still on
		repeat (pet_pkg::PET_PULSE_LEN - 2) begin
			check("out_o", out_o, route);
			@(negedge clk_i);
		end
		repeat (pet_pkg::PET_PULSE_LEN + 2) @(negedge clk_i);
		check("out_o", out_o, 0);
		check("irq_o", irq_o, 0);
		bus_read(pet_pkg::PET_ADR_MSTAT0, v);
		check("mstat bit", v[2], 1);
		bus_write(pet_pkg::PET_ADR_MSTAT0, 64'd1 << 2);
		bus_write(pet_pkg::PET_ADR_MCTRL, 64'd0);
		finish_test("pulse match", e0);
	endtask

	task automatic periodic_reload;
		int e0;
		logic [63:0] c;
		logic [63:0] a;
		logic [63:0] v;
		e0 = errors;
		c = 64'h40000 + rand_bits(8);
		a = 16 + rand_bits(5);
		bus_write(pet_pkg::PET_ADR_MCTRL, 64'd0);
		bus_write(pet_pkg::PET_ADR_COUNTER, c - 12);
		config_timer(3, rand_bits(56), 1'b0, 1'b0, 1'b1, 1'b0);
		// first slot write hits compare, the second one the addend
		bus_write(13'(3 * 16), c);
		bus_write(13'(3 * 16), a);
		bus_read(13'(3 * 16 + 8), v);
		check("cmp_sel", v[pet_pkg::PET_BIT_CMPSEL], 1);
		bus_read(13'(3 * 16), v);
		check("compare", v, c);
		bus_write(pet_pkg::PET_ADR_MCTRL, 64'd1);
		wait_count_past(c);
		bus_read(13'(3 * 16), v);
		check("compare", v, c + a);
		bus_write(pet_pkg::PET_ADR_MSTAT0, 64'd1 << 3);
		wait_count_past(c + a);
		bus_read(13'(3 * 16), v);
		check("compare", v, c + 2 * a);
		bus_write(pet_pkg::PET_ADR_MCTRL, 64'd0);
		finish_test("periodic reload", e0);
	endtask

	// timer 4 lacks ie, timer 5 runs with irq_en off
	task automatic masked_interrupts;
		int e0;
		logic [63:0] route;
		logic [63:0] c;
		logic [63:0] v;
		e0 = errors;
		for (int t = 4; t < 6; t++) begin
			arm_timer(t, t == 5, 1'b0, t == 4, route, c);
			wait_count_past(c);
			bus_read(pet_pkg::PET_ADR_MSTAT0, v);
			check("mstat bit", v[t], 1);
			repeat (3) begin
				check("out_o", out_o, 0);
				check("irq_o", irq_o, 0);
				@(negedge clk_i);
			end
			bus_write(pet_pkg::PET_ADR_MSTAT0, 64'd1 << t);
			bus_write(pet_pkg::PET_ADR_MCTRL, 64'd0);
		end
		finish_test("masked interrupts", e0);
	endtask

	// ====================
	// run
	// ====================

	initial begin
		lfsr_q = 16'd37;
		errors = 0;
		tests_ok = 0;
		tests_bad = 0;
		clk_i = 1'b0;
		rst_i = 1'b1;
		bus_idle();
		repeat (4) @(posedge clk_i);
		@(negedge clk_i);
		rst_i = 1'b0;
		reset_values();
		counter_control();
		level_match();
		pulse_match();
		periodic_reload();
		masked_interrupts();
		$display("tests: %0d passed, %0d failed, %0d check errors", tests_ok, tests_bad, errors);
		if (tests_bad == 0 && errors == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// twice the summed test budgets
	initial begin
		#(WATCHDOG_NS);
		$display("error: run did not finish within %0d ns", WATCHDOG_NS);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
pet_pkg.sv
pet_counter.sv
pet_comparator.sv
pet_output.sv
pet_regs.sv
pet_top.sv
tb_pet.sv

//--- Bender.yml
package:
  name: pet

sources:
  - pet_pkg.sv
  - pet_counter.sv
  - pet_comparator.sv
  - pet_output.sv
  - pet_regs.sv
  - pet_top.sv
  - target: test
    files:
      - tb_pet.sv
